/* hw/rob_settings.svh */
// sizing for the reorder buffer
// ROB_DEPTH must be a power of two and equal to 2**ROB_IDX_W
// the freelist head is one bit narrower than a physical tag

`ifndef ROB_SETTINGS_SVH
`define ROB_SETTINGS_SVH

// --------------------------------------------------
// buffer geometry
// --------------------------------------------------
`define ROB_DEPTH   32  // entries in the circular queue
`define ROB_IDX_W   5   // entry index, pointers carry one extra wrap bit

// --------------------------------------------------
// datapath widths
// --------------------------------------------------
`define PRF_TAG_W   6   // physical register tag
`define ARCH_REG_W  5   // architectural register
`define BR_MASK_W   4   // in-flight branch mask
`define ADDR_W      64  // pc and branch target

`endif

/* hw/rob_pkg.sv */
// types shared by the reorder buffer blocks
// pointers carry a wrap bit above the entry index

`default_nettype none

`include "rob_settings.svh"

package rob_pkg;

	typedef logic [`ROB_IDX_W:0]   rob_ptr_t;  // wrap bit + index
	typedef logic [`ROB_IDX_W-1:0] rob_idx_t;
	typedef logic [`PRF_TAG_W-1:0] prf_tag_t;
	typedef logic [`ARCH_REG_W-1:0] arch_reg_t;
	typedef logic [`BR_MASK_W-1:0] br_mask_t;
	typedef logic [`ADDR_W-1:0]    addr_t;
	typedef logic [`PRF_TAG_W-2:0] fl_head_t;  // freelist head pointer

	// --------------------------------------------------
	// port groups
	// --------------------------------------------------
	typedef struct packed {
		prf_tag_t  new_tag;     // tag from the freelist
		prf_tag_t  old_tag;     // previous mapping, freed at retire
		arch_reg_t arch_dest;
		addr_t     pc;
		logic      br_flag;
		logic      pred_taken;
		addr_t     pred_target;
		br_mask_t  br_mask;
		fl_head_t  fl_head;     // freelist state to restore on recovery
	} rob_dispatch_t;

	typedef struct packed {
		logic     valid;
		rob_ptr_t idx;
		logic     taken;
	} rob_complete_t;

	typedef struct packed {
		logic     valid;
		rob_ptr_t idx;
		logic     taken;   // actual direction
		addr_t    target;  // actual target
	} rob_resolve_t;

	typedef struct packed {
		logic      valid;
		prf_tag_t  new_tag;
		prf_tag_t  old_tag;
		arch_reg_t arch_dest;
	} rob_retire_t;

	typedef struct packed {
		logic     valid;
		br_mask_t br_mask;
		fl_head_t fl_head;
		rob_ptr_t restart_idx;  // new tail, one past the branch
	} rob_recover_t;

	typedef struct packed {
		rob_dispatch_t rec;
		logic          done;
		logic          taken;  // resolved direction from the fu
	} rob_entry_t;

endpackage

`default_nettype wire

/* hw/rob_entry.sv */
// one reorder buffer slot
// a write takes priority over retire clear and completion on the same edge
// the stored record is not reset, only the done bit is

`default_nettype none
`timescale 1ns/1ps

module rob_entry (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  wr_en_i,
	input  rob_pkg::rob_dispatch_t wr_data_i,
	input  logic                  clr_i,
	input  logic                  done_en_i,
	input  logic                  done_taken_i,
	output rob_pkg::rob_entry_t    entry_o
);

	import rob_pkg::*;

	rob_dispatch_t rec_r;
	logic          done_r;
	logic          taken_r;

	// --------------------------------------------------
	// control state
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			done_r <= 1'b0;
		end else if (wr_en_i) begin
			done_r <= 1'b0;  // fresh instruction, not executed yet
		end else if (clr_i) begin
			done_r <= 1'b0;  // retired
		end else if (done_en_i) begin
			done_r <= 1'b1;
		end
	end

	// --------------------------------------------------
	// payload
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (wr_en_i) begin
			rec_r   <= wr_data_i;
			taken_r <= 1'b0;
		end else if (done_en_i) begin
			taken_r <= done_taken_i;  // meaningful only for branches
		end
	end

	always_comb begin
		entry_o.rec   = rec_r;
		entry_o.done  = done_r;
		entry_o.taken = taken_r;
	end

endmodule

`default_nettype wire

/* hw/rob_ptr_ctrl.sv */
// head and tail control for the circular reorder buffer
// a dispatch while stalled, or in a recovery cycle, is dropped
// recovery moves the tail to the restart pointer and wins over dispatch

`default_nettype none
`timescale 1ns/1ps

`include "rob_settings.svh"

module rob_ptr_ctrl (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   dispatch_valid_i,
	input  rob_pkg::rob_complete_t complete_i,
	input  logic                   retire_i,
	input  logic                   recover_i,
	input  rob_pkg::rob_ptr_t      restart_ptr_i,
	output rob_pkg::rob_ptr_t      head_o,
	output rob_pkg::rob_ptr_t      tail_o,
	output logic                   stall_o,
	output logic [`ROB_DEPTH-1:0]  wr_en_o,
	output logic [`ROB_DEPTH-1:0]  clr_o,
	output logic [`ROB_DEPTH-1:0]  done_en_o
);

	import rob_pkg::*;

	localparam logic [`ROB_DEPTH-1:0] one_hot_base = {{(`ROB_DEPTH-1){1'b0}}, 1'b1};

	rob_ptr_t head_r;
	rob_ptr_t tail_r;
	rob_ptr_t occupancy;
	logic     full;
	logic     dispatch_ok;

	// --------------------------------------------------
	// occupancy and stall
	// --------------------------------------------------
	assign occupancy   = tail_r - head_r;  // wrap bit makes full != empty
	assign full        = (occupancy == rob_ptr_t'(`ROB_DEPTH));
	assign stall_o     = full & ~retire_i;  // a retiring head frees a slot
	assign dispatch_ok = dispatch_valid_i & ~stall_o & ~recover_i;

	// per-entry strobes
	assign wr_en_o   = dispatch_ok ? (one_hot_base << tail_r[`ROB_IDX_W-1:0]) : '0;
	assign clr_o     = retire_i ? (one_hot_base << head_r[`ROB_IDX_W-1:0]) : '0;
	assign done_en_o = complete_i.valid ?
		(one_hot_base << complete_i.idx[`ROB_IDX_W-1:0]) : '0;

	// --------------------------------------------------
	// pointers
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			head_r <= '0;
			tail_r <= '0;
		end else begin
			if (retire_i)
				head_r <= head_r + 1'b1;
			if (recover_i)
				tail_r <= restart_ptr_i;  // squash everything younger than the branch
			else if (dispatch_ok)
				tail_r <= tail_r + 1'b1;
		end
	end

	assign head_o = head_r;
	assign tail_o = tail_r;

endmodule

`default_nettype wire

/* hw/rob_retire_sel.sv */
// in-order retirement from the head entry, one per cycle
// payload fields read as zero when nothing retires

`default_nettype none
`timescale 1ns/1ps

`include "rob_settings.svh"

module rob_retire_sel (
	input  rob_pkg::rob_ptr_t                   head_i,
	input  rob_pkg::rob_ptr_t                   tail_i,
	input  rob_pkg::rob_entry_t [`ROB_DEPTH-1:0] entries_i,
	output rob_pkg::rob_retire_t                retire_o,
	output logic                                retire_en_o
);

	import rob_pkg::*;

	rob_idx_t   head_idx;
	rob_entry_t head_entry;
	logic       not_empty;

	assign head_idx   = head_i[`ROB_IDX_W-1:0];
	assign head_entry = entries_i[head_idx];
	assign not_empty  = (head_i != tail_i);  // full pointers, so a full buffer is not empty

	assign retire_en_o = head_entry.done & not_empty;

	// --------------------------------------------------
	// outputs to freelist and architectural map
	// --------------------------------------------------
	always_comb begin
		retire_o = '0;
		if (retire_en_o) begin
			retire_o.valid     = 1'b1;
			retire_o.new_tag   = head_entry.rec.new_tag;
			retire_o.old_tag   = head_entry.rec.old_tag;
			retire_o.arch_dest = head_entry.rec.arch_dest;
		end
	end

endmodule

`default_nettype wire

/* hw/rob_branch_check.sv */
// early branch recovery check against the stored prediction
// direction and target must both match for a correct prediction
// recovery lasts one cycle, a held resolve does not repeat it

`default_nettype none
`timescale 1ns/1ps

`include "rob_settings.svh"

module rob_branch_check (
	input  logic                                clk,
	input  logic                                rst,
	input  rob_pkg::rob_resolve_t               resolve_i,
	input  rob_pkg::rob_entry_t [`ROB_DEPTH-1:0] entries_i,
	output rob_pkg::rob_recover_t               recover_o,
	output logic                                br_right_o
);

	import rob_pkg::*;

	rob_entry_t br_entry;
	logic       is_branch;
	logic       mispredict;
	logic       holdoff_r;  // recovery raised last cycle

	assign br_entry  = entries_i[resolve_i.idx[`ROB_IDX_W-1:0]];
	assign is_branch = resolve_i.valid & br_entry.rec.br_flag;

	assign mispredict = (br_entry.rec.pred_taken != resolve_i.taken) |
		(br_entry.rec.pred_target != resolve_i.target);

	assign br_right_o = is_branch & ~mispredict;

	// --------------------------------------------------
	// recovery payload
	// --------------------------------------------------
	always_comb begin
		recover_o = '0;
		if (is_branch & mispredict & ~holdoff_r) begin
			recover_o.valid       = 1'b1;
			recover_o.br_mask     = br_entry.rec.br_mask;
			recover_o.fl_head     = br_entry.rec.fl_head;
			recover_o.restart_idx = rob_ptr_t'(resolve_i.idx + 1'b1);  // slot after the branch
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			holdoff_r <= 1'b0;
		else
			holdoff_r <= recover_o.valid;
	end

endmodule

`default_nettype wire

/* hw/rob_top.sv */
// reorder buffer top, 32 entries in a circular queue
// dispatch must hold valid low while stall_o is high
// completion and resolve indices are full pointers, the wrap bit is ignored for lookup

`default_nettype none
`timescale 1ns/1ps

`include "rob_settings.svh"

module rob_top (
	input  logic                   clk,
	input  logic                   rst,

	// dispatch
	input  logic                   dispatch_valid_i,
	input  rob_pkg::rob_dispatch_t dispatch_i,
	output rob_pkg::rob_ptr_t      tail_o,     // index given to the next dispatch
	output logic                   stall_o,

	// functional units
	input  rob_pkg::rob_complete_t complete_i,
	input  rob_pkg::rob_resolve_t  resolve_i,

	// retirement and recovery
	output rob_pkg::rob_retire_t   retire_o,
	output rob_pkg::rob_recover_t  recover_o,
	output logic                   br_right_o
);

	import rob_pkg::*;

	rob_ptr_t                   head;
	rob_ptr_t                   tail;
	logic [`ROB_DEPTH-1:0]      wr_en;
	logic [`ROB_DEPTH-1:0]      clr;
	logic [`ROB_DEPTH-1:0]      done_en;
	rob_entry_t [`ROB_DEPTH-1:0] entries;
	logic                       retire_en;
	rob_recover_t               recover;

	// --------------------------------------------------
	// pointer control
	// --------------------------------------------------
	rob_ptr_ctrl u_ptr_ctrl (
		.clk              (clk),
		.rst              (rst),
		.dispatch_valid_i (dispatch_valid_i),
		.complete_i       (complete_i),
		.retire_i         (retire_en),
		.recover_i        (recover.valid),
		.restart_ptr_i    (recover.restart_idx),
		.head_o           (head),
		.tail_o           (tail),
		.stall_o          (stall_o),
		.wr_en_o          (wr_en),
		.clr_o            (clr),
		.done_en_o        (done_en)
	);

	// --------------------------------------------------
	// entry storage
	// --------------------------------------------------
	for (genvar i = 0; i < `ROB_DEPTH; i++) begin : gen_entry
		rob_entry u_entry (
			.clk          (clk),
			.rst          (rst),
			.wr_en_i      (wr_en[i]),
			.wr_data_i    (dispatch_i),
			.clr_i        (clr[i]),
			.done_en_i    (done_en[i]),
			.done_taken_i (complete_i.taken),  // broadcast, strobe picks the slot
			.entry_o      (entries[i])
		);
	end

	// --------------------------------------------------
	// drain side
	// --------------------------------------------------
	rob_retire_sel u_retire_sel (
		.head_i      (head),
		.tail_i      (tail),
		.entries_i   (entries),
		.retire_o    (retire_o),
		.retire_en_o (retire_en)
	);

	rob_branch_check u_branch_check (
		.clk        (clk),
		.rst        (rst),
		.resolve_i  (resolve_i),
		.entries_i  (entries),
		.recover_o  (recover),
		.br_right_o (br_right_o)
	);

	assign recover_o = recover;
	assign tail_o    = tail;

endmodule

`default_nettype wire

/* testbench/rob_tb.sv */
// directed tests for the reorder buffer top, sized for a 32-entry buffer
// inputs change 2 ns after the rising edge, outputs are checked at the falling edge
// a scoreboard queue holds the in-flight records in dispatch order

`default_nettype none
`timescale 1ns/1ps

`include "rob_settings.svh"

module rob_tb;

	import rob_pkg::*;

	localparam int max_cycles = 2000;  // the five tests need a few hundred cycles

	logic          clk;
	logic          rst;
	logic          dispatch_valid;
	rob_dispatch_t dispatch;
	rob_complete_t complete;
	rob_resolve_t  resolve;
	rob_ptr_t      tail;
	logic          stall;
	rob_retire_t   retire;
	rob_recover_t  recover;
	logic          br_right;

	rob_dispatch_t model_q[$];  // in flight, oldest first
	rob_ptr_t      idx_q[$];    // slot of each record in model_q
	int            value_errors = 0;
	int            other_errors = 0;
	int            cycle_count = 0;

	rob_top rob_top_i (
		.clk              (clk),
		.rst              (rst),
		.dispatch_valid_i (dispatch_valid),
		.dispatch_i       (dispatch),
		.tail_o           (tail),
		.stall_o          (stall),
		.complete_i       (complete),
		.resolve_i        (resolve),
		.retire_o         (retire),
		.recover_o        (recover),
		.br_right_o       (br_right)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= max_cycles) begin
			$display("timeout, run stopped after %0d cycles", cycle_count);
			$display("Simulation failed");
			$finish;
		end
	end

	// --------------------------------------------------
	// helpers
	// --------------------------------------------------
	task automatic next_drive;
		@(posedge clk);
		#2;
	endtask

	task automatic wait_sample;
		@(negedge clk);
	endtask

	task automatic report_mismatch(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		value_errors++;
		$display("error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
	endtask

	task automatic report_failure(input string msg);
		other_errors++;
		$display("%s at %0t", msg, $time);
	endtask

	function automatic rob_dispatch_t make_record(input logic br, input logic pt,
		input addr_t tgt);
		rob_dispatch_t r;
		r.new_tag     = prf_tag_t'($urandom);
		r.old_tag     = prf_tag_t'($urandom);
		r.arch_dest   = arch_reg_t'($urandom);
		r.pc          = {$urandom, $urandom};
		r.br_flag     = br;
		r.pred_taken  = pt;
		r.pred_target = tgt;
		r.br_mask     = br_mask_t'($urandom);
		r.fl_head     = fl_head_t'($urandom);
		return r;
	endfunction

	task automatic dispatch_one(input rob_dispatch_t rec, output rob_ptr_t idx);
		idx = tail;
		if (stall !== 1'b0)
			report_mismatch("stall_o", stall, 0);
		dispatch_valid = 1'b1;
		dispatch       = rec;
		model_q.push_back(rec);
		idx_q.push_back(idx);
		next_drive();
		dispatch_valid = 1'b0;
		if (tail !== rob_ptr_t'(idx + 1))
			report_mismatch("tail_o", tail, rob_ptr_t'(idx + 1));
	endtask

	task automatic complete_slot(input rob_ptr_t idx, input logic taken);
		complete.valid = 1'b1;
		complete.idx   = idx;
		complete.taken = taken;
		next_drive();
		complete = '0;
	endtask

	// oldest record in the scoreboard must be the one retiring now
	task automatic check_retire;
		rob_dispatch_t exp;
		if (retire.valid !== 1'b1) begin
			report_mismatch("retire_o.valid", retire.valid, 1);
		end else if (model_q.size() == 0) begin
			report_failure("retirement seen with nothing in flight");
		end else begin
			exp = model_q.pop_front();
			idx_q.delete(0);
			if (retire.new_tag !== exp.new_tag)
				report_mismatch("retire_o.new_tag", retire.new_tag, exp.new_tag);
			if (retire.old_tag !== exp.old_tag)
				report_mismatch("retire_o.old_tag", retire.old_tag, exp.old_tag);
			if (retire.arch_dest !== exp.arch_dest)
				report_mismatch("retire_o.arch_dest", retire.arch_dest, exp.arch_dest);
		end
	endtask

	// complete everything in flight and retire it in order
	task automatic drain_all;
		rob_ptr_t pending[$];
		int       guard;
		pending = idx_q;
		foreach (pending[i]) begin
			complete.valid = 1'b1;
			complete.idx   = pending[i];
			complete.taken = 1'b0;
			wait_sample();
			if (retire.valid === 1'b1)
				check_retire();
			next_drive();
		end
		complete = '0;
		guard    = 0;
		while (model_q.size() > 0 && guard < 8) begin
			wait_sample();
			if (retire.valid === 1'b1)
				check_retire();
			next_drive();
			guard++;
		end
		if (model_q.size() != 0)
			report_failure("buffer did not drain after all entries completed");
	endtask

	// --------------------------------------------------
	// tests
	// --------------------------------------------------
	task automatic test_reset_state;
		wait_sample();
		if (retire.valid !== 1'b0)
			report_mismatch("retire_o.valid", retire.valid, 0);
		if (recover.valid !== 1'b0)
			report_mismatch("recover_o.valid", recover.valid, 0);
		if (br_right !== 1'b0)
			report_mismatch("br_right_o", br_right, 0);
		if (stall !== 1'b0)
			report_mismatch("stall_o", stall, 0);
		if (tail !== '0)
			report_mismatch("tail_o", tail, 0);
		next_drive();
	endtask

	task automatic test_in_order_retire;
		rob_ptr_t idx [4];
		for (int i = 0; i < 4; i++)
			dispatch_one(make_record(1'b0, 1'b0, '0), idx[i]);
		for (int i = 3; i >= 1; i--) begin
			complete_slot(idx[i], 1'b0);
			wait_sample();
			if (retire.valid !== 1'b0)
				report_mismatch("retire_o.valid", retire.valid, 0);  // head not done yet
			else if (retire !== '0)
				report_mismatch("retire_o", retire, 0);  // payload held at zero
			next_drive();
		end
		complete_slot(idx[0], 1'b0);
		for (int i = 0; i < 4; i++) begin
			wait_sample();
			check_retire();
			next_drive();
		end
		wait_sample();
		if (retire.valid !== 1'b0)
			report_mismatch("retire_o.valid", retire.valid, 0);
		next_drive();
	endtask

	task automatic test_full_stall;
		rob_ptr_t first;
		rob_ptr_t idx;
		for (int i = 0; i < `ROB_DEPTH; i++) begin
			dispatch_one(make_record(1'b0, 1'b0, '0), idx);
			if (i == 0)
				first = idx;
		end
		wait_sample();
		if (stall !== 1'b1)
			report_mismatch("stall_o", stall, 1);
		next_drive();
		complete_slot(first, 1'b0);
		wait_sample();
		if (stall !== 1'b0)
			report_mismatch("stall_o", stall, 0);  // head retires, slot frees
		check_retire();
		next_drive();
		drain_all();
	endtask

	task automatic test_branch_right;
		rob_ptr_t idx;
		addr_t    tgt;
		tgt = {$urandom, $urandom};
		dispatch_one(make_record(1'b1, 1'b1, tgt), idx);
		resolve.valid  = 1'b1;
		resolve.idx    = idx;
		resolve.taken  = 1'b1;
		resolve.target = tgt;
		wait_sample();
		if (br_right !== 1'b1)
			report_mismatch("br_right_o", br_right, 1);
		if (recover.valid !== 1'b0)
			report_mismatch("recover_o.valid", recover.valid, 0);
		next_drive();
		resolve = '0;
		drain_all();
	endtask

	task automatic test_branch_recover;
		rob_dispatch_t br_rec;
		rob_ptr_t      br_idx;
		rob_ptr_t      idx;
		rob_ptr_t      restart;
		addr_t         tgt;
		tgt    = {$urandom, $urandom};
		br_rec = make_record(1'b1, 1'b0, tgt);
		dispatch_one(br_rec, br_idx);
		repeat (3)
			dispatch_one(make_record(1'b0, 1'b0, '0), idx);
		restart        = rob_ptr_t'(br_idx + 1);
		resolve.valid  = 1'b1;
		resolve.idx    = br_idx;
		resolve.taken  = 1'b0;
		resolve.target = tgt ^ 64'h40;  // same direction, wrong target
		wait_sample();
		if (recover.valid !== 1'b1)
			report_mismatch("recover_o.valid", recover.valid, 1);
		if (recover.br_mask !== br_rec.br_mask)
			report_mismatch("recover_o.br_mask", recover.br_mask, br_rec.br_mask);
		if (recover.fl_head !== br_rec.fl_head)
			report_mismatch("recover_o.fl_head", recover.fl_head, br_rec.fl_head);
		if (recover.restart_idx !== restart)
			report_mismatch("recover_o.restart_idx", recover.restart_idx, restart);
		if (br_right !== 1'b0)
			report_mismatch("br_right_o", br_right, 0);
		next_drive();
		repeat (3) begin
			void'(model_q.pop_back());  // squashed by the recovery
			void'(idx_q.pop_back());
		end
		wait_sample();
		if (tail !== restart)
			report_mismatch("tail_o", tail, restart);
		if (recover.valid !== 1'b0)
			report_mismatch("recover_o.valid", recover.valid, 0);
		next_drive();
		resolve = '0;
		drain_all();
	endtask

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------
	initial begin
		void'($urandom(32'h75d5_a5fe));
		rst            = 1'b1;
		dispatch_valid = 1'b0;
		dispatch       = '0;
		complete       = '0;
		resolve        = '0;
		repeat (8) @(posedge clk);
		#2;
		rst = 1'b0;

		test_reset_state();
		test_in_order_retire();
		test_full_stall();
		test_branch_right();
		test_branch_recover();

		$display("value errors %0d, other errors %0d", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
+incdir+hw
hw/rob_pkg.sv
hw/rob_entry.sv
hw/rob_ptr_ctrl.sv
hw/rob_retire_sel.sv
hw/rob_branch_check.sv
hw/rob_top.sv
testbench/rob_tb.sv

/* Bender.yml */
package:
  name: rob

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/rob_pkg.sv
      - hw/rob_entry.sv
      - hw/rob_ptr_ctrl.sv
      - hw/rob_retire_sel.sv
      - hw/rob_branch_check.sv
      - hw/rob_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - testbench/rob_tb.sv
